// File: verilog/axil_subsys_cfg.svh
/* Bus and memory sizing for the AXI-Lite memory subsystem.
   Include in any file that needs a width or depth. */
`ifndef AXIL_SUBSYS_CFG_SVH
`define AXIL_SUBSYS_CFG_SVH

// Byte address and data widths of the AXI-Lite port
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

`define AXIL_MEM_DEPTH  1024   // Words of block RAM
`define AXIL_GPIO_WIDTH 8      // Pins in each direction

`endif

// File: verilog/axil_pkg.sv
/* AXI-Lite channel payloads, request and response bundles and response codes,
   shared by every block on the bus. */
`default_nettype none

`include "axil_subsys_cfg.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXIL_STRB_WIDTH-1:0] strb_t;
    typedef logic [1:0]                  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;   // No target at this address

    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;   // Carried but not used
    } aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_t;

    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } ar_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_t;

    // Master to slave
    typedef struct packed {
        aw_t  aw;
        logic awvalid;
        w_t   w;
        logic wvalid;
        logic bready;
        ar_t  ar;
        logic arvalid;
        logic rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic  awready;
        logic  wready;
        resp_t bresp;
        logic  bvalid;
        logic  arready;
        r_t    r;
        logic  rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

// File: verilog/soc_map_pkg.sv
/* Address map of the subsystem and the target select used by the decoder. */
`default_nettype none

`include "axil_subsys_cfg.svh"

package soc_map_pkg;

    // Block RAM region
    localparam logic [`AXIL_ADDR_WIDTH-1:0] MEM_BASE  = 32'h0000_0000;
    localparam logic [`AXIL_ADDR_WIDTH-1:0] MEM_BYTES = 32'h0000_1000;

    // GPIO registers, four words
    localparam logic [`AXIL_ADDR_WIDTH-1:0] GPIO_BASE  = 32'h1000_0000;
    localparam logic [`AXIL_ADDR_WIDTH-1:0] GPIO_BYTES = 32'h0000_0010;

    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_GPIO,
        TGT_NONE    // Unmapped, answered with DECERR
    } target_e;

endpackage

`default_nettype wire

// File: verilog/axil_reg_slice.sv
/* Register slice for one valid/ready channel, with a skid entry so that ready
   comes from a flop and a steady stream still passes at one beat per cycle. */
`timescale 1ns/100ps
`default_nettype none

module axil_reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t skid_data;
    logic     skid_valid;
    logic     skid_valid_nxt;
    logic     out_valid_nxt;
    logic     in_xfer;
    logic     out_load;

    assign in_xfer  = in_valid && in_ready;
    assign out_load = !out_valid || out_ready;   // Output stage free or draining

    always_comb begin
        out_valid_nxt  = out_valid;
        skid_valid_nxt = skid_valid;
        if (out_load) begin
            // Skid entry goes first, in_ready is low while it is full
            out_valid_nxt  = skid_valid || in_xfer;
            skid_valid_nxt = 1'b0;
        end else if (in_xfer) begin
            skid_valid_nxt = 1'b1;                // Output stalled, park the beat
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            out_valid  <= out_valid_nxt;
            skid_valid <= skid_valid_nxt;
            in_ready   <= !skid_valid_nxt;
        end
    end

    always_ff @(posedge aclk) begin
        if (out_load) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (!out_load && in_xfer) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/axil_memory.sv
/* Block-RAM target with byte write strobes and a registered read port.
   Expects aw and w of a write in the same cycle, as the decoder presents them. */
`timescale 1ns/100ps
`default_nettype none

`include "axil_subsys_cfg.svh"

module axil_memory (
    input  logic                aclk,
    input  logic                aresetn,
    input  axil_pkg::axil_req_t req,
    output axil_pkg::axil_rsp_t rsp
);

    localparam int IDX_W = $clog2(`AXIL_MEM_DEPTH);
    localparam int OFS_W = $clog2(`AXIL_STRB_WIDTH);   // Byte offset bits

    axil_pkg::data_t mem [`AXIL_MEM_DEPTH];

    axil_pkg::addr_t wofs;
    axil_pkg::addr_t rofs;
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx;

    logic            wr_rdy;
    logic            bvalid;
    logic            wr_xfer;
    logic            b_xfer;
    logic            rd_rdy;
    logic            rvalid;
    logic            ar_xfer;
    logic            r_xfer;
    logic            bvalid_nxt;
    logic            rvalid_nxt;
    axil_pkg::data_t rdata_q;

    // Word index relative to the region base
    assign wofs = req.aw.addr - soc_map_pkg::MEM_BASE;
    assign rofs = req.ar.addr - soc_map_pkg::MEM_BASE;
    assign widx = wofs[OFS_W +: IDX_W];
    assign ridx = rofs[OFS_W +: IDX_W];

    // Address and data only transfer together
    assign wr_xfer = req.awvalid && req.wvalid && wr_rdy;
    assign b_xfer  = bvalid && req.bready;
    assign ar_xfer = req.arvalid && rd_rdy;
    assign r_xfer  = rvalid && req.rready;

    assign bvalid_nxt = wr_xfer || (bvalid && !b_xfer);
    assign rvalid_nxt = ar_xfer || (rvalid && !r_xfer);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_rdy <= 1'b0;
            bvalid <= 1'b0;
            rd_rdy <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            bvalid <= bvalid_nxt;
            wr_rdy <= !bvalid_nxt;   // No new write while b is pending
            rvalid <= rvalid_nxt;
            rd_rdy <= !rvalid_nxt;   // arready stays low while r is stalled
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_xfer) begin
            for (int i = 0; i < `AXIL_STRB_WIDTH; i++) begin
                if (req.w.strb[i]) begin
                    mem[widx][8*i +: 8] <= req.w.data[8*i +: 8];
                end
            end
        end
    end

    // Read word is loaded only on ar, so it holds under back-pressure
    always_ff @(posedge aclk) begin
        if (ar_xfer) begin
            rdata_q <= mem[ridx];
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = wr_rdy && req.wvalid;
        rsp.wready  = wr_rdy && req.awvalid;
        rsp.bresp   = axil_pkg::RESP_OKAY;
        rsp.bvalid  = bvalid;
        rsp.arready = rd_rdy;
        rsp.r.data  = rdata_q;
        rsp.r.resp  = axil_pkg::RESP_OKAY;
        rsp.rvalid  = rvalid;
    end

endmodule

`default_nettype wire

// File: verilog/axil_decoder.sv
/* Two-way AXI-Lite address decoder with one transaction in flight per direction.
   Unmapped addresses are answered here with DECERR. */
`timescale 1ns/100ps
`default_nettype none

module axil_decoder (
    input  logic                aclk,
    input  logic                aresetn,
    input  axil_pkg::axil_req_t m_req,
    output axil_pkg::axil_rsp_t m_rsp,
    output axil_pkg::axil_req_t mem_req,
    input  axil_pkg::axil_rsp_t mem_rsp,
    output axil_pkg::axil_req_t gpio_req,
    input  axil_pkg::axil_rsp_t gpio_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,   // Request presented to the target
        ST_RESP    // Waiting for the response handshake
    } state_e;

    state_e               wr_state;
    state_e               rd_state;
    soc_map_pkg::target_e wr_tgt;
    soc_map_pkg::target_e rd_tgt;
    axil_pkg::axil_rsp_t  wr_rsp;   // Response of the latched write target
    axil_pkg::axil_rsp_t  rd_rsp;

    function automatic soc_map_pkg::target_e decode(axil_pkg::addr_t addr);
        // Unsigned wrap keeps each range check to a single compare
        if ((addr - soc_map_pkg::MEM_BASE) < soc_map_pkg::MEM_BYTES) begin
            return soc_map_pkg::TGT_MEM;
        end
        if ((addr - soc_map_pkg::GPIO_BASE) < soc_map_pkg::GPIO_BYTES) begin
            return soc_map_pkg::TGT_GPIO;
        end
        return soc_map_pkg::TGT_NONE;
    endfunction

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_state <= ST_IDLE;
            rd_state <= ST_IDLE;
            wr_tgt   <= soc_map_pkg::TGT_NONE;
            rd_tgt   <= soc_map_pkg::TGT_NONE;
        end else begin
            case (wr_state)
                ST_IDLE: if (m_req.awvalid && m_req.wvalid) begin
                    wr_tgt   <= decode(m_req.aw.addr);
                    wr_state <= ST_ADDR;
                end
                ST_ADDR: if (m_rsp.awready && m_rsp.wready) begin
                    wr_state <= ST_RESP;
                end
                ST_RESP: if (m_rsp.bvalid && m_req.bready) begin
                    wr_state <= ST_IDLE;
                end
                default: wr_state <= ST_IDLE;
            endcase
            case (rd_state)
                ST_IDLE: if (m_req.arvalid) begin
                    rd_tgt   <= decode(m_req.ar.addr);
                    rd_state <= ST_ADDR;
                end
                ST_ADDR: if (m_rsp.arready) begin
                    rd_state <= ST_RESP;
                end
                ST_RESP: if (m_rsp.rvalid && m_req.rready) begin
                    rd_state <= ST_IDLE;
                end
                default: rd_state <= ST_IDLE;
            endcase
        end
    end

    // Pick the responding target, or a local DECERR slave
    always_comb begin
        case (wr_tgt)
            soc_map_pkg::TGT_MEM:  wr_rsp = mem_rsp;
            soc_map_pkg::TGT_GPIO: wr_rsp = gpio_rsp;
            default: begin
                wr_rsp         = '0;
                wr_rsp.awready = 1'b1;
                wr_rsp.wready  = 1'b1;
                wr_rsp.bresp   = axil_pkg::RESP_DECERR;
                wr_rsp.bvalid  = 1'b1;
            end
        endcase
        case (rd_tgt)
            soc_map_pkg::TGT_MEM:  rd_rsp = mem_rsp;
            soc_map_pkg::TGT_GPIO: rd_rsp = gpio_rsp;
            default: begin
                rd_rsp         = '0;      // Read data of an unmapped read is zero
                rd_rsp.arready = 1'b1;
                rd_rsp.r.resp  = axil_pkg::RESP_DECERR;
                rd_rsp.rvalid  = 1'b1;
            end
        endcase
    end

    always_comb begin
        m_rsp         = '0;
        m_rsp.awready = (wr_state == ST_ADDR) && wr_rsp.awready;
        m_rsp.wready  = (wr_state == ST_ADDR) && wr_rsp.wready;
        m_rsp.bresp   = wr_rsp.bresp;
        m_rsp.bvalid  = (wr_state == ST_RESP) && wr_rsp.bvalid;
        m_rsp.arready = (rd_state == ST_ADDR) && rd_rsp.arready;
        m_rsp.r       = rd_rsp.r;
        m_rsp.rvalid  = (rd_state == ST_RESP) && rd_rsp.rvalid;
    end

    // Payloads fan out, valids and readies go to the selected target only
    always_comb begin
        mem_req          = m_req;
        mem_req.awvalid  = (wr_state == ST_ADDR) && (wr_tgt == soc_map_pkg::TGT_MEM);
        mem_req.wvalid   = mem_req.awvalid;
        mem_req.bready   = (wr_state == ST_RESP) && (wr_tgt == soc_map_pkg::TGT_MEM)
                           && m_req.bready;
        mem_req.arvalid  = (rd_state == ST_ADDR) && (rd_tgt == soc_map_pkg::TGT_MEM);
        mem_req.rready   = (rd_state == ST_RESP) && (rd_tgt == soc_map_pkg::TGT_MEM)
                           && m_req.rready;
        gpio_req         = m_req;
        gpio_req.awvalid = (wr_state == ST_ADDR) && (wr_tgt == soc_map_pkg::TGT_GPIO);
        gpio_req.wvalid  = gpio_req.awvalid;
        gpio_req.bready  = (wr_state == ST_RESP) && (wr_tgt == soc_map_pkg::TGT_GPIO)
                           && m_req.bready;
        gpio_req.arvalid = (rd_state == ST_ADDR) && (rd_tgt == soc_map_pkg::TGT_GPIO);
        gpio_req.rready  = (rd_state == ST_RESP) && (rd_tgt == soc_map_pkg::TGT_GPIO)
                           && m_req.rready;
    end

endmodule

`default_nettype wire

// File: verilog/axil_gpio.sv
/* GPIO target, offset 0 is the output register and offset 4 the synchronized inputs.
   Handshake timing matches the memory target. */
`timescale 1ns/100ps
`default_nettype none

`include "axil_subsys_cfg.svh"

module axil_gpio (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  axil_pkg::axil_req_t          req,
    output axil_pkg::axil_rsp_t          rsp,
    input  logic [`AXIL_GPIO_WIDTH-1:0]  gpio_in,
    output logic [`AXIL_GPIO_WIDTH-1:0]  gpio_out
);

    localparam int OFS_W = $clog2(`AXIL_STRB_WIDTH);

    axil_pkg::addr_t             wofs;
    axil_pkg::addr_t             rofs;
    logic [`AXIL_GPIO_WIDTH-1:0] wmask;
    logic [`AXIL_GPIO_WIDTH-1:0] sync_meta;   // First synchronizer stage
    logic [`AXIL_GPIO_WIDTH-1:0] sync_q;
    logic                        wr_rdy;
    logic                        bvalid;
    logic                        rd_rdy;
    logic                        rvalid;
    logic                        wr_xfer;
    logic                        ar_xfer;
    logic                        bvalid_nxt;
    logic                        rvalid_nxt;
    axil_pkg::data_t             rdata_q;

    assign wofs    = req.aw.addr - soc_map_pkg::GPIO_BASE;
    assign rofs    = req.ar.addr - soc_map_pkg::GPIO_BASE;
    assign wr_xfer = req.awvalid && req.wvalid && wr_rdy;
    assign ar_xfer = req.arvalid && rd_rdy;

    assign bvalid_nxt = wr_xfer || (bvalid && !req.bready);
    assign rvalid_nxt = ar_xfer || (rvalid && !req.rready);

    // Each output pin follows the strobe of its byte lane
    always_comb begin
        for (int i = 0; i < `AXIL_GPIO_WIDTH; i++) begin
            wmask[i] = req.w.strb[i / 8];
        end
    end

    always_ff @(posedge aclk) begin
        sync_meta <= gpio_in;
        sync_q    <= sync_meta;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_rdy   <= 1'b0;
            bvalid   <= 1'b0;
            rd_rdy   <= 1'b0;
            rvalid   <= 1'b0;
            gpio_out <= '0;
        end else begin
            bvalid <= bvalid_nxt;
            wr_rdy <= !bvalid_nxt;
            rvalid <= rvalid_nxt;
            rd_rdy <= !rvalid_nxt;
            if (wr_xfer && (wofs[OFS_W +: 2] == 2'd0)) begin   // Input register ignores writes
                gpio_out <= (gpio_out & ~wmask)
                            | (req.w.data[`AXIL_GPIO_WIDTH-1:0] & wmask);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_xfer) begin
            case (rofs[OFS_W +: 2])
                2'd0:    rdata_q <= axil_pkg::data_t'(gpio_out);
                2'd1:    rdata_q <= axil_pkg::data_t'(sync_q);
                default: rdata_q <= '0;
            endcase
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = wr_rdy && req.wvalid;
        rsp.wready  = wr_rdy && req.awvalid;
        rsp.bresp   = axil_pkg::RESP_OKAY;
        rsp.bvalid  = bvalid;
        rsp.arready = rd_rdy;
        rsp.r.data  = rdata_q;
        rsp.r.resp  = axil_pkg::RESP_OKAY;
        rsp.rvalid  = rvalid;
    end

endmodule

`default_nettype wire

// File: verilog/axil_subsys_top.sv
/* AXI-Lite memory subsystem. Slices on aw, w and ar feed the decoder,
   which serves the block RAM and the GPIO registers. */
`timescale 1ns/100ps
`default_nettype none

`include "axil_subsys_cfg.svh"

module axil_subsys_top (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  axil_pkg::axil_req_t          s_req,
    output axil_pkg::axil_rsp_t          s_rsp,
    input  logic [`AXIL_GPIO_WIDTH-1:0]  gpio_in,
    output logic [`AXIL_GPIO_WIDTH-1:0]  gpio_out
);

    axil_pkg::aw_t       aw_q;
    axil_pkg::w_t        w_q;
    axil_pkg::ar_t       ar_q;
    logic                aw_q_valid;
    logic                w_q_valid;
    logic                ar_q_valid;
    logic                aw_ready;
    logic                w_ready;
    logic                ar_ready;
    axil_pkg::axil_req_t dec_req;
    axil_pkg::axil_rsp_t dec_rsp;
    axil_pkg::axil_req_t mem_req;
    axil_pkg::axil_rsp_t mem_rsp;
    axil_pkg::axil_req_t gpio_req;
    axil_pkg::axil_rsp_t gpio_rsp;

    axil_reg_slice #(.payload_t(axil_pkg::aw_t)) u_aw_slice (
        .aclk, .aresetn,
        .in_data(s_req.aw), .in_valid(s_req.awvalid), .in_ready(aw_ready),
        .out_data(aw_q), .out_valid(aw_q_valid), .out_ready(dec_rsp.awready)
    );

    axil_reg_slice #(.payload_t(axil_pkg::w_t)) u_w_slice (
        .aclk, .aresetn,
        .in_data(s_req.w), .in_valid(s_req.wvalid), .in_ready(w_ready),
        .out_data(w_q), .out_valid(w_q_valid), .out_ready(dec_rsp.wready)
    );

    axil_reg_slice #(.payload_t(axil_pkg::ar_t)) u_ar_slice (
        .aclk, .aresetn,
        .in_data(s_req.ar), .in_valid(s_req.arvalid), .in_ready(ar_ready),
        .out_data(ar_q), .out_valid(ar_q_valid), .out_ready(dec_rsp.arready)
    );

    // b and r bypass the slices
    assign dec_req = '{aw: aw_q, awvalid: aw_q_valid, w: w_q, wvalid: w_q_valid,
                       bready: s_req.bready, ar: ar_q, arvalid: ar_q_valid,
                       rready: s_req.rready};
    assign s_rsp   = '{awready: aw_ready, wready: w_ready, bresp: dec_rsp.bresp,
                       bvalid: dec_rsp.bvalid, arready: ar_ready, r: dec_rsp.r,
                       rvalid: dec_rsp.rvalid};

    axil_decoder u_decoder (
        .aclk, .aresetn,
        .m_req(dec_req), .m_rsp(dec_rsp),
        .mem_req, .mem_rsp,
        .gpio_req, .gpio_rsp
    );

    axil_memory u_memory (
        .aclk, .aresetn,
        .req(mem_req), .rsp(mem_rsp)
    );

    axil_gpio u_gpio (
        .aclk, .aresetn,
        .req(gpio_req), .rsp(gpio_rsp),
        .gpio_in, .gpio_out
    );

endmodule

`default_nettype wire

// File: verification/axil_subsys_properties.sv
/* Handshake checks on the slave port of the subsystem, bound into the top level.
   Each check raises its flag when it fires. */
`timescale 1ns/100ps
`default_nettype none

module axil_subsys_properties (
    input logic                aclk,
    input logic                aresetn,
    input axil_pkg::axil_req_t s_req,
    input axil_pkg::axil_rsp_t s_rsp
);

    logic b_err   = 1'b0;
    logic r_err   = 1'b0;
    logic rst_err = 1'b0;

    // A stalled write response keeps valid and its code
    b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_rsp.bvalid && !s_req.bready |=> s_rsp.bvalid && $stable(s_rsp.bresp))
        else begin
            $error("write response dropped or changed before bready");
            b_err = 1'b1;
        end

    r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_rsp.rvalid && !s_req.rready |=> s_rsp.rvalid && $stable(s_rsp.r))
        else begin
            $error("read response dropped or changed before rready");
            r_err = 1'b1;
        end

    // Valids and readies stay low through the first cycle after reset
    rst_quiet: assert property (@(posedge aclk)
        !aresetn |=> !(s_rsp.awready || s_rsp.wready || s_rsp.arready
                       || s_rsp.bvalid || s_rsp.rvalid))
        else begin
            $error("handshake output active in the cycle after reset");
            rst_err = 1'b1;
        end

endmodule

bind axil_subsys_top axil_subsys_properties u_props (
    .aclk(aclk),
    .aresetn(aresetn),
    .s_req(s_req),
    .s_rsp(s_rsp)
);

`default_nettype wire

// File: verification/axil_subsys_tb.sv
/* Testbench for the AXI-Lite memory subsystem. Drives the slave port, keeps a
   reference model and checks every b and r handshake against it. */
`timescale 1ns/100ps
`default_nettype none

`include "axil_subsys_cfg.svh"

module axil_subsys_tb;

    localparam integer          SEED     = 32'h1451_cbcd;
    localparam int              N_WORDS  = 64;
    localparam axil_pkg::addr_t UNMAPPED = 32'h2000_0000;   // Outside both regions

    typedef logic [`AXIL_GPIO_WIDTH-1:0] gpio_t;

    logic                aclk    = 1'b0;
    logic                aresetn = 1'b0;
    axil_pkg::addr_t     aw_addr = '0;
    axil_pkg::data_t     w_data  = '0;
    axil_pkg::strb_t     w_strb  = '0;
    axil_pkg::addr_t     ar_addr = '0;
    logic                awvalid = 1'b0;
    logic                wvalid  = 1'b0;
    logic                arvalid = 1'b0;
    logic                bready  = 1'b0;
    logic                rready  = 1'b0;
    gpio_t               gpio_in = '0;
    gpio_t               gpio_out;
    axil_pkg::axil_req_t s_req;
    axil_pkg::axil_rsp_t s_rsp;

    integer seed    = SEED;
    integer bp_seed = SEED;   // Separate stream for the ready pattern
    int     cycles  = 0;
    int     b_seen  = 0;
    int     r_seen  = 0;

    // Reference model and expected responses in issue order
    axil_pkg::data_t ref_mem [`AXIL_MEM_DEPTH];
    gpio_t           ref_gpio = '0;
    int              idx_list [N_WORDS];
    axil_pkg::resp_t exp_b [$];
    axil_pkg::r_t    exp_r [$];

    assign s_req = '{aw: '{addr: aw_addr, prot: 3'b000}, awvalid: awvalid,
                     w: '{data: w_data, strb: w_strb}, wvalid: wvalid, bready: bready,
                     ar: '{addr: ar_addr, prot: 3'b000}, arvalid: arvalid, rready: rready};

    axil_subsys_top DUT (
        .aclk, .aresetn,
        .s_req, .s_rsp,
        .gpio_in, .gpio_out
    );

    always #5 aclk = ~aclk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input axil_pkg::data_t exp,
                                   input axil_pkg::data_t got);
        abort_run($sformatf("mismatch at %0t: %s expected 0x%08h, got 0x%08h",
                            $time, name, exp, got));
    endtask

    // Byte lanes with a set strobe take the new data
    function automatic axil_pkg::data_t merge_bytes(axil_pkg::data_t old_word,
                                                    axil_pkg::data_t new_word,
                                                    axil_pkg::strb_t strb);
        axil_pkg::data_t result;
        result = old_word;
        for (int i = 0; i < `AXIL_STRB_WIDTH; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic write_word(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                              input axil_pkg::strb_t strb, input axil_pkg::resp_t resp);
        logic aw_done;
        logic w_done;
        @(negedge aclk);
        aw_addr = addr;
        w_data  = data;
        w_strb  = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        exp_b.push_back(resp);
        while (awvalid || wvalid) begin
            #1;   // Readies are settled until the next rising edge
            aw_done = awvalid && s_rsp.awready;
            w_done  = wvalid && s_rsp.wready;
            @(negedge aclk);
            if (aw_done) begin
                awvalid = 1'b0;
            end
            if (w_done) begin
                wvalid = 1'b0;
            end
        end
        while (b_seen != exp_b.size()) begin
            @(negedge aclk);
        end
    endtask

    task automatic read_word(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                             input axil_pkg::resp_t resp);
        axil_pkg::r_t exp;
        logic         ar_done;
        exp.data = data;
        exp.resp = resp;
        @(negedge aclk);
        ar_addr = addr;
        arvalid = 1'b1;
        exp_r.push_back(exp);
        do begin
            #1;
            ar_done = s_rsp.arready;
            @(negedge aclk);
        end while (!ar_done);
        arvalid = 1'b0;
        while (r_seen != exp_r.size()) begin
            @(negedge aclk);
        end
    endtask

    task automatic mem_write(input int idx, input axil_pkg::data_t data,
                             input axil_pkg::strb_t strb);
        ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
        write_word(soc_map_pkg::MEM_BASE + axil_pkg::addr_t'(idx * 4), data, strb,
                   axil_pkg::RESP_OKAY);
    endtask

    task automatic mem_check(input int idx);
        read_word(soc_map_pkg::MEM_BASE + axil_pkg::addr_t'(idx * 4), ref_mem[idx],
                  axil_pkg::RESP_OKAY);
    endtask

    // Response checks, sampled after the falling-edge drive
    always begin
        @(negedge aclk);
        #1;
        if (aresetn) begin
            if (DUT.u_props.b_err || DUT.u_props.r_err || DUT.u_props.rst_err) begin
                abort_run("a handshake assertion failed at the slave port");
            end
            if (s_rsp.bvalid && bready) begin
                assert (b_seen < exp_b.size())
                    else abort_run("write response arrived with no write outstanding");
                assert (s_rsp.bresp == exp_b[b_seen])
                    else report_mismatch("bresp", axil_pkg::data_t'(exp_b[b_seen]),
                                         axil_pkg::data_t'(s_rsp.bresp));
                b_seen++;
            end
            if (s_rsp.rvalid && rready) begin
                assert (r_seen < exp_r.size())
                    else abort_run("read response arrived with no read outstanding");
                assert (s_rsp.r.resp == exp_r[r_seen].resp)
                    else report_mismatch("rresp", axil_pkg::data_t'(exp_r[r_seen].resp),
                                         axil_pkg::data_t'(s_rsp.r.resp));
                assert (s_rsp.r.data == exp_r[r_seen].data)
                    else report_mismatch("rdata", exp_r[r_seen].data, s_rsp.r.data);
                r_seen++;
            end
        end
    end

    // Random stretches of back-pressure on b and r
    always @(negedge aclk) begin
        if (($random(bp_seed) & 3) == 0) begin
            bready <= !bready;
        end
        if (($random(bp_seed) & 3) == 0) begin
            rready <= !rready;
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles > 20 * (exp_b.size() + exp_r.size()) + 200) begin
            abort_run($sformatf("timeout after %0d cycles waiting for a response", cycles));
        end
    end

    initial begin
        axil_pkg::data_t word;
        axil_pkg::addr_t bad_addr;
        repeat (2) @(negedge aclk);
        aresetn = 1'b1;

        for (int i = 0; i < N_WORDS; i++) begin
            idx_list[i] = $random(seed) & (`AXIL_MEM_DEPTH - 1);
            mem_write(idx_list[i], $random(seed), '1);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            mem_check(idx_list[i]);
        end

        // Partial writes merge into the word already there
        for (int i = 0; i < N_WORDS; i++) begin
            mem_write(idx_list[i], $random(seed), axil_pkg::strb_t'($random(seed)));
            mem_check(idx_list[i]);
        end

        word     = $random(seed);
        ref_gpio = gpio_t'(merge_bytes(axil_pkg::data_t'(ref_gpio), word, 4'b0001));
        write_word(soc_map_pkg::GPIO_BASE, word, 4'b0001, axil_pkg::RESP_OKAY);
        assert (gpio_out == ref_gpio)
            else report_mismatch("gpio_out", axil_pkg::data_t'(ref_gpio),
                                 axil_pkg::data_t'(gpio_out));
        read_word(soc_map_pkg::GPIO_BASE, axil_pkg::data_t'(ref_gpio), axil_pkg::RESP_OKAY);
        @(negedge aclk);
        gpio_in = gpio_t'($random(seed));
        repeat (4) @(negedge aclk);   // Past the two synchronizer flops
        read_word(soc_map_pkg::GPIO_BASE + 4, axil_pkg::data_t'(gpio_in), axil_pkg::RESP_OKAY);

        // Low bits alias a written memory word
        bad_addr = UNMAPPED | axil_pkg::addr_t'(idx_list[0] * 4);
        write_word(bad_addr, $random(seed), '1, axil_pkg::RESP_DECERR);
        read_word(bad_addr, '0, axil_pkg::RESP_DECERR);
        for (int i = 0; i < N_WORDS; i++) begin
            mem_check(idx_list[i]);
        end

        if (DUT.u_props.b_err || DUT.u_props.r_err || DUT.u_props.rst_err) begin
            abort_run("a handshake assertion failed at the slave port");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/axil_pkg.sv
verilog/soc_map_pkg.sv
verilog/axil_reg_slice.sv
verilog/axil_memory.sv
verilog/axil_decoder.sv
verilog/axil_gpio.sv
verilog/axil_subsys_top.sv
verification/axil_subsys_properties.sv
verification/axil_subsys_tb.sv

// File: Makefile
# Verilator build and run of the AXI-Lite memory subsystem testbench
VERILATOR ?= verilator
TOP       ?= axil_subsys_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/axil_subsys_cfg.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
